/* flist.f */
rtl/axi_mem_pkg.sv
rtl/mem_cmd_if.sv
rtl/mem_access_splitter.sv
rtl/mem_cmd_queue.sv
rtl/axi_mem_master.sv
rtl/lsu_axi_top.sv
verification/axi_mem_model.sv
verification/lsu_axi_assertions.sv
verification/tb_lsu_axi.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f flist.f --top-module tb_lsu_axi -o sim_tb
./obj_dir/sim_tb > sim.log || { cat sim.log; exit 1; }
cat sim.log

if grep -q "test failed" sim.log; then
	exit 1
fi
exit 0

/* verification/tb_lsu_axi.sv */
////////////////////////////////////////////////////////////////////////////
// Directed tests of lsu_axi_top against the behavioral AXI memory.
// Core addresses are memory offsets; no checked access crosses 0x100.
// Expected responses come from a reference byte array kept in issue order.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_lsu_axi;

	// worst two-beat write with 7-cycle waits, plus queue and response
	localparam int access_count = 48;
	localparam int cycles_per_access = 48;
	localparam int cycle_limit = access_count * cycles_per_access + 10;

	logic clk;
	logic rst_n;
	logic req, we, ack;
	logic [63:0] addr, wdata;
	logic [7:0] wstrb;
	logic rsp_valid, rsp_err;
	logic [63:0] rsp_data;
	logic awvalid, awready, wvalid, wready, wlast, bvalid, bready;
	logic arvalid, arready, rvalid, rready, rlast;
	logic [3:0] awid, arid;
	logic [63:0] awaddr, araddr, axi_wdata, rdata;
	logic [7:0] awlen, arlen, axi_wstrb;
	logic [2:0] awsize, arsize, max_wait;
	logic [1:0] awburst, arburst, bresp, rresp;

	logic [7:0] ref_mem [256];
	logic exp_err [$];
	logic exp_check [$];
	logic [63:0] exp_data [$];
	logic [7:0] exp_len [$];
	logic [63:0] exp_addr [$];
	int errors;
	int rsp_count;
	int cycles;

	lsu_axi_top u_dut (.*);
	axi_mem_model u_mem (.*);

	bind lsu_axi_top lsu_axi_assertions u_assert (.*);

	always #20 clk = ~clk;

	task automatic report_mismatch(input string name, input logic [63:0] exp,
		input logic [63:0] act);
		errors++;
		$display("Fail at %0t: %s expected %h, got %h", $time, name, exp, act);
	endtask

	// one fixed ID, 8-byte beats, INCR bursts
	task automatic check_attributes(input string ch, input logic [3:0] id,
		input logic [2:0] size, input logic [1:0] burst);
		if (id !== axi_mem_pkg::axi_id_mem) begin
			report_mismatch({ch, "id"}, 64'(axi_mem_pkg::axi_id_mem), 64'(id));
		end
		if (size !== 3'b011) begin
			report_mismatch({ch, "size"}, 64'd3, 64'(size));
		end
		if (burst !== 2'b01) begin
			report_mismatch({ch, "burst"}, 64'd1, 64'(burst));
		end
	endtask

	function automatic logic [63:0] expected_load(input logic [63:0] a);
		logic [63:0] d;
		for (int i = 0; i < 8; i++) begin
			d[8*i +: 8] = ref_mem[a[7:0] + 8'(i)];
		end
		return d;
	endfunction

	task automatic update_ref(input logic [63:0] a, input logic [63:0] d, input logic [7:0] s);
		for (int i = 0; i < 8; i++) begin
			if (s[i]) begin
				ref_mem[a[7:0] + 8'(i)] = d[8*i +: 8];
			end
		end
	endtask

	// one four-phase request; returns once ack has dropped
	task automatic send(input logic is_wr, input logic [63:0] a, input logic [63:0] d,
		input logic [7:0] s);
		logic err;
		err = (a[63:8] != '0);
		exp_err.push_back(err);
		exp_check.push_back(!is_wr && !err);
		exp_data.push_back(expected_load(a));
		exp_len.push_back((a[2:0] != 3'd0) ? 8'd1 : 8'd0);
		exp_addr.push_back({a[63:3], 3'b000} + axi_mem_pkg::mem_base);
		if (is_wr && !err) begin
			update_ref(a, d, s);
		end
		req = 1'b1;
		we = is_wr;
		addr = a;
		wdata = d;
		wstrb = s;
		while (!ack) @(negedge clk);
		req = 1'b0;
		while (ack) @(negedge clk);
	endtask

	task automatic drain();
		while (exp_err.size() != 0) @(negedge clk);
		repeat (4) @(negedge clk);
		if (exp_len.size() != 0) begin
			errors++;
			$display("AXI address phase missing for %0d requests", exp_len.size());
		end
	endtask

	task automatic check_reset_state();
		if (ack !== 1'b0) report_mismatch("ack", 64'd0, 64'(ack));
		if (rsp_valid !== 1'b0) report_mismatch("rsp_valid", 64'd0, 64'(rsp_valid));
		if (awvalid !== 1'b0) report_mismatch("awvalid", 64'd0, 64'(awvalid));
		if (wvalid !== 1'b0) report_mismatch("wvalid", 64'd0, 64'(wvalid));
		if (arvalid !== 1'b0) report_mismatch("arvalid", 64'd0, 64'(arvalid));
	endtask

	task automatic aligned_round_trip();
		send(1'b1, 64'h40, 64'h0123_4567_89ab_cdef, 8'hff);
		send(1'b0, 64'h40, 64'h0, 8'h00);
		drain();
	endtask

	task automatic unaligned_round_trips();
		logic [63:0] a;
		for (int b = 1; b < 8; b++) begin
			a = 64'h40 + 64'(17 * b);
			send(1'b1, a, 64'h0102_0304_0506_0708 * 64'(b + 8), 8'hff);
			send(1'b0, a, 64'h0, 8'h00);
			send(1'b0, {a[63:3], 3'b000}, 64'h0, 8'h00);
			send(1'b0, {a[63:3], 3'b000} + 64'd8, 64'h0, 8'h00);
		end
		drain();
	endtask

	task automatic partial_strobe_store();
		send(1'b1, 64'hc8, 64'haaaa_bbbb_cccc_dddd, 8'b0101_0010);
		send(1'b0, 64'hc8, 64'h0, 8'h00);
		send(1'b1, 64'hd3, 64'h1111_2222_3333_4444, 8'h0f);
		send(1'b0, 64'hd0, 64'h0, 8'h00);
		send(1'b0, 64'hd8, 64'h0, 8'h00);
		drain();
	endtask

	task automatic backpressure_burst();
		max_wait = 3'd7;
		for (int k = 0; k < 4; k++) begin
			send(1'b1, 64'h08 + 64'(11 * k), {8{8'(8'h30 + k)}}, 8'hff);
		end
		for (int k = 0; k < 4; k++) begin
			send(1'b0, 64'h08 + 64'(11 * k), 64'h0, 8'h00);
		end
		drain();
		max_wait = 3'd2;
	endtask

	task automatic error_window_access();
		send(1'b0, 64'h100, 64'h0, 8'h00);
		send(1'b1, 64'h108, 64'hdead_beef_dead_beef, 8'hff);
		send(1'b0, 64'h30, 64'h0, 8'h00);
		drain();
	endtask

	always @(negedge clk) begin : rsp_monitor
		logic err_exp;
		logic data_chk;
		logic [63:0] data_exp;
		if (rst_n && rsp_valid) begin
			rsp_count++;
			if (exp_err.size() == 0) begin
				errors++;
				$display("response pulse at %0t with no request outstanding", $time);
			end else begin
				err_exp = exp_err.pop_front();
				data_chk = exp_check.pop_front();
				data_exp = exp_data.pop_front();
				if (rsp_err !== err_exp) begin
					report_mismatch("rsp_err", 64'(err_exp), 64'(rsp_err));
				end
				if (data_chk && rsp_data !== data_exp) begin
					report_mismatch("rsp_data", data_exp, rsp_data);
				end
			end
		end
	end

	// burst length, bus address and attributes of each transaction, in issue order
	always @(posedge clk) begin : addr_monitor
		logic [7:0] len_exp;
		logic [63:0] addr_exp;
		if (rst_n && ((awvalid && awready) || (arvalid && arready))) begin
			if (exp_len.size() == 0) begin
				errors++;
				$display("AXI address phase at %0t with no request outstanding", $time);
			end else begin
				len_exp = exp_len.pop_front();
				addr_exp = exp_addr.pop_front();
				if (awvalid) begin
					if (awlen !== len_exp) begin
						report_mismatch("awlen", 64'(len_exp), 64'(awlen));
					end
					if (awaddr !== addr_exp) begin
						report_mismatch("awaddr", addr_exp, awaddr);
					end
					check_attributes("aw", awid, awsize, awburst);
				end
				if (arvalid) begin
					if (arlen !== len_exp) begin
						report_mismatch("arlen", 64'(len_exp), 64'(arlen));
					end
					if (araddr !== addr_exp) begin
						report_mismatch("araddr", addr_exp, araddr);
					end
					check_attributes("ar", arid, arsize, arburst);
				end
			end
		end
	end

	// the model shows B and R for a single cycle only
	always @(posedge clk) begin : resp_ready_monitor
		if (rst_n && bvalid && bready !== 1'b1) begin
			report_mismatch("bready", 64'd1, 64'(bready));
		end
		if (rst_n && rvalid && rready !== 1'b1) begin
			report_mismatch("rready", 64'd1, 64'(rready));
		end
	end

	initial begin
		cycles = 0;
		while (cycles < cycle_limit) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout: run did not finish within %0d cycles", cycle_limit);
		$display("test failed");
		$finish;
	end

	initial begin
		clk = 1'b0;
		rst_n = 1'b0;
		req = 1'b0;
		we = 1'b0;
		addr = '0;
		wdata = '0;
		wstrb = '0;
		max_wait = 3'd2;
		errors = 0;
		rsp_count = 0;
		for (int i = 0; i < 256; i++) begin
			ref_mem[i] = 8'(i) ^ 8'h5a;
		end
		repeat (5) @(negedge clk);
		check_reset_state();
		rst_n = 1'b1;
		aligned_round_trip();
		unaligned_round_trips();
		partial_strobe_store();
		backpressure_burst();
		error_window_access();
		$display("responses: %0d, errors: %0d", rsp_count, errors);
		if (errors == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

/* verification/lsu_axi_assertions.sv */
////////////////////////////////////////////////////////////////////////////
// Handshake rules on the bridge ports, bound into lsu_axi_top.
// Assumes awlen stays stable for the whole write burst.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module lsu_axi_assertions (
	input logic clk,
	input logic rst_n,
	input logic req,
	input logic ack,
	input logic awvalid,
	input logic awready,
	input logic [axi_mem_pkg::addr_w-1:0] awaddr,
	input logic [axi_mem_pkg::len_w-1:0] awlen,
	input logic wvalid,
	input logic wready,
	input logic [axi_mem_pkg::data_w-1:0] axi_wdata,
	input logic [axi_mem_pkg::strb_w-1:0] axi_wstrb,
	input logic wlast,
	input logic arvalid,
	input logic arready,
	input logic [axi_mem_pkg::addr_w-1:0] araddr
);

	// W beats done in the current burst
	logic [axi_mem_pkg::len_w-1:0] w_count;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			w_count <= '0;
		end else if (wvalid && wready) begin
			w_count <= wlast ? '0 : w_count + 1'b1;
		end
	end

	aw_hold: assert property (@(posedge clk) disable iff (!rst_n)
		awvalid && !awready |=> awvalid && $stable(awaddr) && $stable(awlen))
		else $error("awvalid dropped or AW fields changed before awready");

	w_hold: assert property (@(posedge clk) disable iff (!rst_n)
		wvalid && !wready |=> wvalid && $stable(axi_wdata) && $stable(axi_wstrb))
		else $error("wvalid dropped or W data changed before wready");

	ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
		arvalid && !arready |=> arvalid && $stable(araddr))
		else $error("arvalid dropped or araddr changed before arready");

	wlast_final: assert property (@(posedge clk) disable iff (!rst_n)
		wvalid |-> (wlast == (w_count == awlen)))
		else $error("wlast does not mark the final W beat");

	ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(ack) |-> $past(req))
		else $error("ack rose without a request");

endmodule

/* verification/axi_mem_model.sv */
////////////////////////////////////////////////////////////////////////////
// Behavioral AXI4 slave: 256-byte memory seen at mem_base, one burst at a
// time. Ready and valid waits are random, up to max_wait cycles.
// Offsets 0x100 and up form the error window: SLVERR, and no write.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module axi_mem_model (
	input logic clk,
	input logic rst_n,
	input logic [2:0] max_wait,
	input logic awvalid,
	output logic awready,
	input logic [axi_mem_pkg::addr_w-1:0] awaddr,
	input logic [axi_mem_pkg::len_w-1:0] awlen,
	input logic wvalid,
	output logic wready,
	input logic [axi_mem_pkg::data_w-1:0] axi_wdata,
	input logic [axi_mem_pkg::strb_w-1:0] axi_wstrb,
	output logic bvalid,
	output logic [axi_mem_pkg::resp_w-1:0] bresp,
	input logic arvalid,
	output logic arready,
	input logic [axi_mem_pkg::addr_w-1:0] araddr,
	input logic [axi_mem_pkg::len_w-1:0] arlen,
	output logic rvalid,
	output logic [axi_mem_pkg::data_w-1:0] rdata,
	output logic [axi_mem_pkg::resp_w-1:0] rresp,
	output logic rlast
);

	localparam logic [axi_mem_pkg::resp_w-1:0] resp_slverr = 2'b10;

	logic [7:0] mem [256];
	integer seed;
	logic [axi_mem_pkg::addr_w-1:0] offset;
	logic [axi_mem_pkg::len_w-1:0] len;
	logic bad;

	task automatic pause();
		int n;
		n = $unsigned($random(seed)) % (int'(max_wait) + 1);
		repeat (n) @(negedge clk);
	endtask

	task automatic serve_write();
		pause();
		awready = 1'b1;
		offset = awaddr - axi_mem_pkg::mem_base;
		len = awlen;
		bad = (offset[axi_mem_pkg::addr_w-1:8] != '0);
		@(negedge clk);
		awready = 1'b0;
		for (int beat = 0; beat <= int'(len); beat++) begin
			while (!wvalid) @(negedge clk);
			pause();
			wready = 1'b1;
			for (int i = 0; i < 8; i++) begin
				if (axi_wstrb[i] && !bad) begin
					mem[offset[7:0] + 8'(8 * beat + i)] = axi_wdata[8*i +: 8];
				end
			end
			@(negedge clk);
			wready = 1'b0;
		end
		pause();
		bvalid = 1'b1;
		bresp = bad ? resp_slverr : axi_mem_pkg::axi_resp_okay;
		@(negedge clk);
		bvalid = 1'b0;
	endtask

	task automatic serve_read();
		pause();
		arready = 1'b1;
		offset = araddr - axi_mem_pkg::mem_base;
		len = arlen;
		bad = (offset[axi_mem_pkg::addr_w-1:8] != '0);
		@(negedge clk);
		arready = 1'b0;
		for (int beat = 0; beat <= int'(len); beat++) begin
			pause();
			for (int i = 0; i < 8; i++) begin
				rdata[8*i +: 8] = mem[offset[7:0] + 8'(8 * beat + i)];
			end
			rresp = bad ? resp_slverr : axi_mem_pkg::axi_resp_okay;
			rlast = (beat == int'(len));
			rvalid = 1'b1;
			@(negedge clk);
			rvalid = 1'b0;
			rlast = 1'b0;
		end
	endtask

	initial begin
		seed = 87637;
		awready = 1'b0;
		wready = 1'b0;
		bvalid = 1'b0;
		bresp = '0;
		arready = 1'b0;
		rvalid = 1'b0;
		rdata = '0;
		rresp = '0;
		rlast = 1'b0;
		for (int i = 0; i < 256; i++) begin
			mem[i] = 8'(i) ^ 8'h5a;
		end
		forever begin
			@(negedge clk);
			if (rst_n && awvalid) begin
				serve_write();
			end else if (rst_n && arvalid) begin
				serve_read();
			end
		end
	end

endmodule

/* rtl/lsu_axi_top.sv */
////////////////////////////////////////////////////////////////////////////
// Load/store bus bridge: four-phase core port to a single AXI4 master.
// Up to queue_depth requests wait in the queue; responses stay in order.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module lsu_axi_top (
	input logic clk,
	input logic rst_n,
	// core request
	input logic req,
	input logic we,
	input logic [axi_mem_pkg::addr_w-1:0] addr,
	input logic [axi_mem_pkg::data_w-1:0] wdata,
	input logic [axi_mem_pkg::strb_w-1:0] wstrb,
	output logic ack,
	// core response
	output logic rsp_valid,
	output logic rsp_err,
	output logic [axi_mem_pkg::data_w-1:0] rsp_data,
	// AXI
	output logic awvalid,
	input logic awready,
	output logic [axi_mem_pkg::id_w-1:0] awid,
	output logic [axi_mem_pkg::addr_w-1:0] awaddr,
	output logic [axi_mem_pkg::len_w-1:0] awlen,
	output logic [axi_mem_pkg::size_w-1:0] awsize,
	output logic [axi_mem_pkg::burst_w-1:0] awburst,
	output logic wvalid,
	input logic wready,
	output logic [axi_mem_pkg::data_w-1:0] axi_wdata,
	output logic [axi_mem_pkg::strb_w-1:0] axi_wstrb,
	output logic wlast,
	input logic bvalid,
	output logic bready,
	input logic [axi_mem_pkg::resp_w-1:0] bresp,
	output logic arvalid,
	input logic arready,
	output logic [axi_mem_pkg::id_w-1:0] arid,
	output logic [axi_mem_pkg::addr_w-1:0] araddr,
	output logic [axi_mem_pkg::len_w-1:0] arlen,
	output logic [axi_mem_pkg::size_w-1:0] arsize,
	output logic [axi_mem_pkg::burst_w-1:0] arburst,
	input logic rvalid,
	output logic rready,
	input logic [axi_mem_pkg::data_w-1:0] rdata,
	input logic [axi_mem_pkg::resp_w-1:0] rresp,
	input logic rlast
);

	mem_cmd_if cmd_in ();
	mem_cmd_if cmd_out ();

	mem_access_splitter u_splitter (
		.clk(clk),
		.rst_n(rst_n),
		.req(req),
		.we(we),
		.addr(addr),
		.wdata(wdata),
		.wstrb(wstrb),
		.ack(ack),
		.cmd_in(cmd_in)
	);

	mem_cmd_queue u_queue (
		.clk(clk),
		.rst_n(rst_n),
		.cmd_in(cmd_in),
		.cmd_out(cmd_out)
	);

	// core and bus both have a wdata, so the bus side is prefixed
	axi_mem_master u_master (
		.clk(clk),
		.rst_n(rst_n),
		.cmd_out(cmd_out),
		.rsp_valid(rsp_valid),
		.rsp_err(rsp_err),
		.rsp_data(rsp_data),
		.awvalid(awvalid),
		.awready(awready),
		.awid(awid),
		.awaddr(awaddr),
		.awlen(awlen),
		.awsize(awsize),
		.awburst(awburst),
		.wvalid(wvalid),
		.wready(wready),
		.wdata(axi_wdata),
		.wstrb(axi_wstrb),
		.wlast(wlast),
		.bvalid(bvalid),
		.bready(bready),
		.bresp(bresp),
		.arvalid(arvalid),
		.arready(arready),
		.arid(arid),
		.araddr(araddr),
		.arlen(arlen),
		.arsize(arsize),
		.arburst(arburst),
		.rvalid(rvalid),
		.rready(rready),
		.rdata(rdata),
		.rresp(rresp),
		.rlast(rlast)
	);

endmodule

/* rtl/axi_mem_master.sv */
////////////////////////////////////////////////////////////////////////////
// AXI4 master for queued commands, one transaction at a time, in order.
// Fixed ID, 8-byte size, INCR bursts of one or two beats.
// rsp_valid pulses once per command, the cycle after B or the last R beat.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module axi_mem_master (
	input logic clk,
	input logic rst_n,
	mem_cmd_if.consumer cmd_out,
	output logic rsp_valid,
	output logic rsp_err,
	output logic [axi_mem_pkg::data_w-1:0] rsp_data,
	// write address
	output logic awvalid,
	input logic awready,
	output logic [axi_mem_pkg::id_w-1:0] awid,
	output logic [axi_mem_pkg::addr_w-1:0] awaddr,
	output logic [axi_mem_pkg::len_w-1:0] awlen,
	output logic [axi_mem_pkg::size_w-1:0] awsize,
	output logic [axi_mem_pkg::burst_w-1:0] awburst,
	// write data
	output logic wvalid,
	input logic wready,
	output logic [axi_mem_pkg::data_w-1:0] wdata,
	output logic [axi_mem_pkg::strb_w-1:0] wstrb,
	output logic wlast,
	// write response
	input logic bvalid,
	output logic bready,
	input logic [axi_mem_pkg::resp_w-1:0] bresp,
	// read address
	output logic arvalid,
	input logic arready,
	output logic [axi_mem_pkg::id_w-1:0] arid,
	output logic [axi_mem_pkg::addr_w-1:0] araddr,
	output logic [axi_mem_pkg::len_w-1:0] arlen,
	output logic [axi_mem_pkg::size_w-1:0] arsize,
	output logic [axi_mem_pkg::burst_w-1:0] arburst,
	// read data
	input logic rvalid,
	output logic rready,
	input logic [axi_mem_pkg::data_w-1:0] rdata,
	input logic [axi_mem_pkg::resp_w-1:0] rresp,
	input logic rlast
);

	typedef enum logic [2:0] {
		st_idle,
		st_wr,
		st_wresp,
		st_rd_addr,
		st_rd_data
	} state_t;

	state_t state;
	axi_mem_pkg::mem_cmd_t cmd_q;
	logic w_beat;
	logic err_acc;
	logic rd_bad;
	logic pop;
	logic aw_ok;
	logic w_ok;
	logic [axi_mem_pkg::len_w-1:0] burst_len;
	logic [axi_mem_pkg::data_w-1:0] rd_beat0;
	logic [2*axi_mem_pkg::data_w-1:0] rd_pair;
	logic [2*axi_mem_pkg::data_w-1:0] rd_shift;

	// next command only once the previous response has gone out
	assign cmd_out.ready = (state == st_idle) && !rsp_valid;
	assign pop = cmd_out.valid && cmd_out.ready;

	assign burst_len = cmd_q.len_pair ? axi_mem_pkg::axi_len_pair : axi_mem_pkg::axi_len_single;

	assign awid = axi_mem_pkg::axi_id_mem;
	assign awaddr = cmd_q.addr;
	assign awlen = burst_len;
	assign awsize = axi_mem_pkg::axi_size_double;
	assign awburst = axi_mem_pkg::axi_burst_incr;

	assign wdata = w_beat ? cmd_q.beat1_data : cmd_q.beat0_data;
	assign wstrb = w_beat ? cmd_q.beat1_strb : cmd_q.beat0_strb;
	assign wlast = wvalid && (w_beat == cmd_q.len_pair);

	assign arid = axi_mem_pkg::axi_id_mem;
	assign araddr = cmd_q.addr;
	assign arlen = burst_len;
	assign arsize = axi_mem_pkg::axi_size_double;
	assign arburst = axi_mem_pkg::axi_burst_incr;

	// both write channels finished by this edge
	assign aw_ok = !awvalid || awready;
	assign w_ok = !wvalid || (wready && wlast);

	assign rd_bad = (rresp != axi_mem_pkg::axi_resp_okay);

	// bytes bias..7 of beat0, then bytes 0..bias-1 of beat1
	assign rd_pair = cmd_q.len_pair ? {rdata, rd_beat0} : {{axi_mem_pkg::data_w{1'b0}}, rdata};
	assign rd_shift = rd_pair >> (8 * cmd_q.bias);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= st_idle;
			awvalid <= 1'b0;
			wvalid <= 1'b0;
			bready <= 1'b0;
			arvalid <= 1'b0;
			rready <= 1'b0;
			rsp_valid <= 1'b0;
			w_beat <= 1'b0;
		end else begin
			rsp_valid <= 1'b0;
			case (state)
				st_idle: begin
					if (pop) begin
						w_beat <= 1'b0;
						if (cmd_out.cmd.is_write) begin
							awvalid <= 1'b1;
							wvalid <= 1'b1;
							state <= st_wr;
						end else begin
							arvalid <= 1'b1;
							state <= st_rd_addr;
						end
					end
				end
				st_wr: begin
					if (awvalid && awready) begin
						awvalid <= 1'b0;
					end
					if (wvalid && wready) begin
						if (wlast) begin
							wvalid <= 1'b0;
						end else begin
							w_beat <= 1'b1;
						end
					end
					if (aw_ok && w_ok) begin
						bready <= 1'b1;
						state <= st_wresp;
					end
				end
				st_wresp: begin
					if (bvalid) begin
						bready <= 1'b0;
						rsp_valid <= 1'b1;
						state <= st_idle;
					end
				end
				st_rd_addr: begin
					if (arready) begin
						arvalid <= 1'b0;
						rready <= 1'b1;
						state <= st_rd_data;
					end
				end
				st_rd_data: begin
					if (rvalid && rlast) begin
						rready <= 1'b0;
						rsp_valid <= 1'b1;
						state <= st_idle;
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (pop) begin
			cmd_q <= cmd_out.cmd;
			err_acc <= 1'b0;
		end
		if (bready && bvalid) begin
			rsp_err <= (bresp != axi_mem_pkg::axi_resp_okay);
		end
		if (rready && rvalid) begin
			err_acc <= err_acc | rd_bad;
			if (rlast) begin
				rsp_data <= rd_shift[axi_mem_pkg::data_w-1:0];
				rsp_err <= err_acc | rd_bad;
			end else begin
				rd_beat0 <= rdata;
			end
		end
	end

endmodule

/* rtl/mem_cmd_queue.sv */
////////////////////////////////////////////////////////////////////////////
// In-order command FIFO of queue_depth entries.
// ready drops when full. Push and pop may happen on the same edge.
// queue_depth must be a power of two.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module mem_cmd_queue (
	input logic clk,
	input logic rst_n,
	mem_cmd_if.consumer cmd_in,
	mem_cmd_if.producer cmd_out
);

	axi_mem_pkg::mem_cmd_t mem [axi_mem_pkg::queue_depth];
	logic [axi_mem_pkg::queue_ptr_w-1:0] wr_ptr;
	logic [axi_mem_pkg::queue_ptr_w-1:0] rd_ptr;
	logic [axi_mem_pkg::queue_ptr_w:0] count;
	logic push;
	logic pop;

	assign cmd_in.ready = (count != (axi_mem_pkg::queue_ptr_w + 1)'(axi_mem_pkg::queue_depth));
	assign cmd_out.valid = (count != '0);
	assign cmd_out.cmd = mem[rd_ptr];

	assign push = cmd_in.valid && cmd_in.ready;
	assign pop = cmd_out.valid && cmd_out.ready;

	always_ff @(posedge clk) begin
		if (push) begin
			mem[wr_ptr] <= cmd_in.cmd;
		end
	end

	// pointers wrap on their own at the end of the buffer
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

/* rtl/mem_access_splitter.sv */
////////////////////////////////////////////////////////////////////////////
// Core-side four-phase port. One request is taken per req/ack cycle.
// ack means queued, not done. Unaligned accesses become two beats with
// data and strobes shifted up by the low address bits.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module mem_access_splitter (
	input logic clk,
	input logic rst_n,
	input logic req,
	input logic we,
	input logic [axi_mem_pkg::addr_w-1:0] addr,
	input logic [axi_mem_pkg::data_w-1:0] wdata,
	input logic [axi_mem_pkg::strb_w-1:0] wstrb,
	output logic ack,
	mem_cmd_if.producer cmd_in
);

	logic [axi_mem_pkg::bias_w-1:0] bias;
	logic [2*axi_mem_pkg::data_w-1:0] data_pair;
	logic [2*axi_mem_pkg::strb_w-1:0] strb_pair;
	logic [axi_mem_pkg::addr_w-1:0] bus_addr;
	logic cmd_valid;
	logic take;
	axi_mem_pkg::mem_cmd_t cmd_reg;

	assign bias = addr[axi_mem_pkg::bias_w-1:0];

	// low bytes land in beat0, the overflow in beat1
	assign data_pair = {{axi_mem_pkg::data_w{1'b0}}, wdata} << (8 * bias);
	assign strb_pair = {{axi_mem_pkg::strb_w{1'b0}}, wstrb} << bias;

	assign bus_addr = {addr[axi_mem_pkg::addr_w-1:axi_mem_pkg::bias_w],
		{axi_mem_pkg::bias_w{1'b0}}} + axi_mem_pkg::mem_base;

	// new request only once the previous handshake has returned to zero
	assign take = req && !cmd_valid && !ack;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			cmd_valid <= 1'b0;
			ack <= 1'b0;
		end else begin
			if (take) begin
				cmd_valid <= 1'b1;
			end else if (cmd_valid && cmd_in.ready) begin
				cmd_valid <= 1'b0;
				ack <= 1'b1;
			end
			// return to zero
			if (ack && !req) begin
				ack <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (take) begin
			cmd_reg.is_write <= we;
			cmd_reg.addr <= bus_addr;
			cmd_reg.len_pair <= |bias;
			cmd_reg.bias <= bias;
			cmd_reg.beat0_data <= data_pair[axi_mem_pkg::data_w-1:0];
			cmd_reg.beat1_data <= data_pair[2*axi_mem_pkg::data_w-1:axi_mem_pkg::data_w];
			cmd_reg.beat0_strb <= strb_pair[axi_mem_pkg::strb_w-1:0];
			cmd_reg.beat1_strb <= strb_pair[2*axi_mem_pkg::strb_w-1:axi_mem_pkg::strb_w];
		end
	end

	assign cmd_in.valid = cmd_valid;
	assign cmd_in.cmd = cmd_reg;

endmodule

/* rtl/mem_cmd_if.sv */
////////////////////////////////////////////////////////////////////////////
// Command channel with valid/ready.
// A transfer happens on an edge with valid and ready both high; valid
// holds with a stable cmd until then.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

interface mem_cmd_if;

	logic valid;
	logic ready;
	axi_mem_pkg::mem_cmd_t cmd;

	modport producer (
		output valid,
		output cmd,
		input ready
	);

	modport consumer (
		input valid,
		input cmd,
		output ready
	);

endinterface

/* rtl/axi_mem_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// Shared widths, AXI encodings and the command format of the LSU bridge.
// Only 8-byte transfers are used, as one beat or a two-beat INCR burst.
// mem_base is added to every aligned address on the bus.
////////////////////////////////////////////////////////////////////////////

package axi_mem_pkg;

	localparam int addr_w = 64;
	localparam int data_w = 64;
	localparam int strb_w = data_w / 8;
	localparam int bias_w = $clog2(strb_w);

	// AXI field widths
	localparam int id_w = 4;
	localparam int len_w = 8;
	localparam int size_w = 3;
	localparam int burst_w = 2;
	localparam int resp_w = 2;

	localparam int queue_depth = 4;
	localparam int queue_ptr_w = $clog2(queue_depth);

	localparam logic [addr_w-1:0] mem_base = 64'h0000_0000_8000_0000;

	localparam logic [id_w-1:0] axi_id_mem = 4'h1;
	localparam logic [size_w-1:0] axi_size_double = 3'b011;
	localparam logic [burst_w-1:0] axi_burst_incr = 2'b01;
	localparam logic [len_w-1:0] axi_len_single = 8'd0;
	localparam logic [len_w-1:0] axi_len_pair = 8'd1;
	localparam logic [resp_w-1:0] axi_resp_okay = 2'b00;

	// one access as it goes on the bus
	typedef struct packed {
		logic is_write;
		logic [addr_w-1:0] addr;
		logic len_pair;
		logic [bias_w-1:0] bias;
		logic [data_w-1:0] beat0_data;
		logic [data_w-1:0] beat1_data;
		logic [strb_w-1:0] beat0_strb;
		logic [strb_w-1:0] beat1_strb;
	} mem_cmd_t;

endpackage
